//--- testbench/fu_vectors.mem
// inst     a                b                tag stall value            illegal
// stall is the number of cycles stall stays high while the op waits at issue
40220403 7FFFFFFFFFFFFFFF 0000000000000001 01 0 8000000000000000 0
40220523 0000000000000005 0000000000000007 02 0 FFFFFFFFFFFFFFFE 0
44220003 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 03 0 F000F000F000F000 0
44220103 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 04 0 00F000F000F000F0 0
44220403 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 05 0 FFF0FFF0FFF0FFF0 0
44220503 0000000000000000 00000000000000FF 06 0 FFFFFFFFFFFFFF00 0
44220803 123456789ABCDEF0 FFFFFFFF00000000 07 0 EDCBA9879ABCDEF0 0
44220903 123456789ABCDEF0 0F0F0F0F0F0F0F0F 08 0 E2C4A6886A4C2E00 0
48220683 8000000000000010 0000000000000004 09 0 0800000000000001 0
48220723 00000000000000FF 0000000000000104 0A 0 0000000000000FF0 0
48220783 8000000000000000 0000000000000004 0B 0 F800000000000000 0
48220783 FFFFFFFFFFFFFF00 0000000000000008 0C 0 FFFFFFFFFFFFFFFF 0
48220783 7000000000000000 000000000000003C 0D 0 0000000000000007 0
402203A3 0000000000000001 FFFFFFFFFFFFFFFF 0E 0 0000000000000001 0
402209A3 0000000000000001 FFFFFFFFFFFFFFFF 0F 0 0000000000000000 0
40220DA3 FFFFFFFFFFFFFFFF 0000000000000001 10 0 0000000000000001 0
402207A3 FFFFFFFFFFFFFFFF 0000000000000001 11 0 0000000000000000 0
402205A3 0000000000000123 0000000000000123 12 0 0000000000000001 0
402209A3 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFF 13 0 0000000000000001 0
402FF403 0000000000000100 FFFFFFFFFFFFFFFF 14 0 000000000000017F 0
403FF3A3 0000000000000080 0000000000000000 15 0 0000000000000001 0
4421F003 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 16 0 000000000000000F 0
48241723 00000000DEADBEEF 0000000000000000 17 0 DEADBEEF00000000 0
4C220403 0000000000000003 0000000000000005 18 0 000000000000000F 0
4C220403 FFFFFFFFFFFFFFFF 0000000000000007 19 0 FFFFFFFFFFFFFFF9 0
4C220403 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFD 1A 0 0000000000000006 0
4C220403 0000000100000001 0000000100000001 1B 0 0000000200000001 0
4C220403 123456789ABCDEF0 0000000000000010 1C 0 23456789ABCDEF00 0
40220403 0000000000000010 0000000000000020 1D 0 0000000000000030 0
4C221403 0000000000000ABC FFFFFFFFFFFFFFFF 1E 0 000000000000ABC0 0
40220403 0000000000000001 0000000000000001 1F 3 0000000000000002 0
4C220403 00000000FFFFFFFF 00000000FFFFFFFF 20 2 FFFFFFFE00000001 0
40220FE3 0000000000000055 0000000000000066 21 0 0000000000000000 1
FC220403 0000000000000055 0000000000000066 22 1 0000000000000000 1
4C220603 0000000000000007 0000000000000009 23 0 0000000000000000 1
4C220403 C000000000000001 0000000000000004 24 0 0000000000000004 0

//--- verilog.f
+incdir+design
design/fu_pkg.sv
design/operand_decode.sv
design/alu.sv
design/mult_stage.sv
design/mult.sv
design/complete_arbiter.sv
design/fu_bank.sv
testbench/fu_bank_tb.sv

//--- Makefile
SIM       = verilator
FLAGS     = --binary --timing --timescale 1ns/100ps
TOP       = fu_bank_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# build and run, a $fatal in the testbench gives a failing exit status
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/fu_bank_tb.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module fu_bank_tb;

  localparam int NUM_VECTORS = 36;
  // inst, a, b, tag, stall, value, illegal
  localparam int FIELDS = 7;
  localparam int MAX_GAP = 2;
  localparam int NUM_TAGS = 1 << `FU_TAG_BITS;

  logic                  clock;
  logic                  reset;
  logic                  issue_valid;
  logic                  stall;
  fu_pkg::issue_packet_t issue;
  logic                  issue_ready;
  logic                  complete_valid;
  fu_pkg::fu_result_t    complete;

  logic [`FU_WORD_BITS-1:0] vec_mem [0:NUM_VECTORS*FIELDS-1];
  fu_pkg::fu_result_t       expected_of_tag [0:NUM_TAGS-1];
  logic                     tag_pending [0:NUM_TAGS-1];
  logic                     tag_seen [0:NUM_TAGS-1];
  int                       vec_of_tag [0:NUM_TAGS-1];
  int                       done_count;
  int                       cycle_count;
  int                       cycle_limit;
  int                       drain_cycles;

  fu_bank fu_bank_inst (
    .clock          (clock),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .stall          (stall),
    .issue          (issue),
    .issue_ready    (issue_ready),
    .complete_valid (complete_valid),
    .complete       (complete)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // issue packet straight from one vector line
  function automatic fu_pkg::issue_packet_t packet_of(input int idx);
    fu_pkg::issue_packet_t pkt;
    pkt.inst    = vec_mem[idx*FIELDS][31:0];
    pkt.a_value = vec_mem[idx*FIELDS+1];
    pkt.b_value = vec_mem[idx*FIELDS+2];
    pkt.tag     = vec_mem[idx*FIELDS+3][`FU_TAG_BITS-1:0];
    return pkt;
  endfunction

  // what the completion bus should carry for this vector
  function automatic fu_pkg::fu_result_t expected_of(input int idx);
    fu_pkg::fu_result_t res;
    res.value   = vec_mem[idx*FIELDS+5];
    res.tag     = vec_mem[idx*FIELDS+3][`FU_TAG_BITS-1:0];
    res.illegal = vec_mem[idx*FIELDS+6][0];
    return res;
  endfunction

  task automatic check_result(input string name, input fu_pkg::fu_result_t expected,
                              input fu_pkg::fu_result_t actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h tag %0d illegal %b, actual %h tag %0d illegal %b",
               name, expected.value, expected.tag, expected.illegal,
               actual.value, actual.tag, actual.illegal);
      $display("TESTBENCH FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "completion count mismatch");
    end
  endtask

  // read the vector file, build the per-tag table and the cycle budget
  task automatic load_vectors();
    int total_stall;
    logic [`FU_TAG_BITS-1:0] tag;
    total_stall = 0;
    $readmemh("testbench/fu_vectors.mem", vec_mem);
    for (int t = 0; t < NUM_TAGS; t++) begin
      tag_pending[t] = 1'b0;
      tag_seen[t]    = 1'b0;
    end
    for (int i = 0; i < NUM_VECTORS; i++) begin
      for (int f = 0; f < FIELDS; f++) begin
        if ($isunknown(vec_mem[i*FIELDS+f])) begin
          $display("ERROR: vector file is short or holds unknown values at vector %0d", i);
          $display("TESTBENCH FAILED");
          $fatal(1, "bad vector file");
        end
      end
      tag = vec_mem[i*FIELDS+3][`FU_TAG_BITS-1:0];
      // tags must be unique or the lookup breaks
      if (tag_seen[tag]) begin
        $display("ERROR: vector %0d reuses tag %0d", i, tag);
        $display("TESTBENCH FAILED");
        $fatal(1, "duplicate tag in vector file");
      end
      tag_seen[tag]        = 1'b1;
      vec_of_tag[tag]      = i;
      expected_of_tag[tag] = expected_of(i);
      total_stall += int'(vec_mem[i*FIELDS+4][15:0]);
    end
    cycle_limit = NUM_VECTORS * (`FU_MULT_STAGES + 2 + MAX_GAP) + total_stall + 100;
  endtask

  // present one vector, hold it until taken, stall for its count of cycles
  task automatic issue_vector(input int idx);
    int   gap;
    int   stall_left;
    logic taken;
    // multiplies go back to back, other ops get a random idle gap
    if (vec_mem[idx*FIELDS][31:26] == 6'h13) begin
      gap = 0;
    end else begin
      gap = int'($urandom % (MAX_GAP + 1));
    end
    stall_left = int'(vec_mem[idx*FIELDS+4][15:0]);
    repeat (gap) begin
      issue_valid <= 1'b0;
      stall       <= 1'b0;
      @(posedge clock);
    end
    issue_valid <= 1'b1;
    issue       <= packet_of(idx);
    stall       <= (stall_left != 0);
    taken = 1'b0;
    while (!taken) begin
      // ready is settled mid cycle
      @(negedge clock);
      taken = (issue_ready === 1'b1);
      if (taken) begin
        tag_pending[vec_mem[idx*FIELDS+3][`FU_TAG_BITS-1:0]] = 1'b1;
      end
      @(posedge clock);
      if (stall_left != 0) begin
        stall_left--;
      end
      if (!taken) begin
        stall <= (stall_left != 0);
      end
    end
  endtask

  // look up a finished result by tag
  task automatic record_completion(input fu_pkg::fu_result_t actual);
    int idx;
    if (tag_pending[actual.tag] !== 1'b1) begin
      $display("ERROR: completion with tag %0d that was never issued or already completed",
               actual.tag);
      $display("TESTBENCH FAILED");
      $fatal(1, "unexpected completion tag");
    end
    idx = vec_of_tag[actual.tag];
    check_result($sformatf("vector %0d tag %0d", idx, actual.tag),
                 expected_of_tag[actual.tag], actual);
    tag_pending[actual.tag] = 1'b0;
    done_count++;
  endtask

  // completion bus is registered, stable at the falling edge
  always @(negedge clock) begin
    if (complete_valid === 1'b1) begin
      record_completion(complete);
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("ERROR: timeout after %0d cycles, only %0d of %0d results completed",
               cycle_count, done_count, NUM_VECTORS);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    done_count  = 0;
    cycle_count = 0;
    void'($urandom(32'h687c879f));
    reset       <= 1'b1;
    issue_valid <= 1'b0;
    stall       <= 1'b0;
    issue       <= '0;
    load_vectors();
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      issue_vector(i);
    end
    issue_valid <= 1'b0;
    stall       <= 1'b0;
    // no stall after the last issue, so the pipe drains within its depth
    drain_cycles = 0;
    while (done_count < NUM_VECTORS && drain_cycles < `FU_MULT_STAGES + 2) begin
      @(posedge clock);
      drain_cycles++;
    end
    // room for a stray extra completion to show up
    repeat (`FU_MULT_STAGES + 2) @(posedge clock);
    check_count("completion count", NUM_VECTORS, done_count);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- design/fu_bank.sv
`timescale 1ns/100ps

module fu_bank (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue_valid,
  input  logic                 stall,
  input  fu_pkg::issue_packet_t issue,
  output logic                 issue_ready,
  output logic                 complete_valid,
  output fu_pkg::fu_result_t   complete
);

  fu_pkg::exec_packet_t alu_op;
  fu_pkg::exec_packet_t mult_op;
  logic                illegal;
  fu_pkg::fu_result_t  alu_result;
  fu_pkg::fu_result_t  mult_result;
  logic                alu_done;
  logic                alu_ready;
  logic                mult_done;
  logic                mult_ready;
  logic                alu_hazard;
  logic                mult_hazard;

  // split the issued op toward one unit
  operand_decode decode_inst (
    .issue_valid (issue_valid),
    .issue       (issue),
    .alu_op      (alu_op),
    .mult_op     (mult_op),
    .illegal     (illegal)
  );

  alu alu_inst (
    .op      (alu_op),
    .illegal (illegal),
    .hazard  (alu_hazard),
    .result  (alu_result),
    .done    (alu_done),
    .ready   (alu_ready)
  );

  mult mult_inst (
    .clock  (clock),
    .reset  (reset),
    .op     (mult_op),
    .hazard (mult_hazard),
    .result (mult_result),
    .done   (mult_done),
    .ready  (mult_ready)
  );

  // one registered completion bus
  complete_arbiter arbiter_inst (
    .clock          (clock),
    .reset          (reset),
    .stall          (stall),
    .alu_result     (alu_result),
    .mult_result    (mult_result),
    .alu_done       (alu_done),
    .mult_done      (mult_done),
    .alu_hazard     (alu_hazard),
    .mult_hazard    (mult_hazard),
    .complete_valid (complete_valid),
    .complete       (complete)
  );

  // ready comes from whichever unit the op is headed for
  // idle issue falls on the alu side, high unless stalled op
  assign issue_ready = mult_op.valid ? mult_ready : alu_ready;

endmodule

//--- design/complete_arbiter.sv
`timescale 1ns/100ps

module complete_arbiter (
  input  logic               clock,
  input  logic               reset,
  input  logic               stall,
  input  fu_pkg::fu_result_t alu_result,
  input  fu_pkg::fu_result_t mult_result,
  input  logic               alu_done,
  input  logic               mult_done,
  output logic               alu_hazard,
  output logic               mult_hazard,
  output logic               complete_valid,
  output fu_pkg::fu_result_t complete
);

  logic take_mult;
  logic take_alu;

  // fixed priority, multiplier first
  // its pipe cannot hold off new ops without freezing everything
  assign take_mult = !stall && mult_done;
  assign take_alu  = !stall && !mult_done && alu_done;

  // stall blocks both, a multiplier win blocks the alu
  assign mult_hazard = stall;
  assign alu_hazard  = stall || mult_done;

  // one completion per cycle at most
  always_ff @(posedge clock) begin
    if (reset) begin
      complete_valid <= 1'b0;
    end else begin
      complete_valid <= take_mult || take_alu;
    end
  end

  // payload only loads on a winner
  always_ff @(posedge clock) begin
    if (take_mult) begin
      complete <= mult_result;
    end else if (take_alu) begin
      complete <= alu_result;
    end
  end

endmodule

//--- design/mult.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module mult (
  input  logic                clock,
  input  logic                reset,
  input  fu_pkg::exec_packet_t op,
  input  logic                hazard,
  output fu_pkg::fu_result_t  result,
  output logic                done,
  output logic                ready
);

  localparam int STAGES = `FU_MULT_STAGES;

  // entry k feeds stage k, entry STAGES is the last stage output
  logic [`FU_WORD_BITS-1:0] prod_chain   [0:STAGES];
  logic [`FU_WORD_BITS-1:0] mplier_chain [0:STAGES];
  logic [`FU_WORD_BITS-1:0] mcand_chain  [0:STAGES];
  logic [STAGES:0]          start_chain;
  logic [`FU_TAG_BITS-1:0]  tag_q        [0:STAGES-1];

  // product starts at zero, a is the multiplier
  assign prod_chain[0]   = '0;
  assign mplier_chain[0] = op.a;
  assign mcand_chain[0]  = op.b;
  assign start_chain[0]  = op.valid;

  for (genvar k = 0; k < STAGES; k++) begin : g_stage
    mult_stage stage_inst (
      .clock        (clock),
      .reset        (reset),
      .start        (start_chain[k]),
      .hazard       (hazard),
      .product_in   (prod_chain[k]),
      .mplier_in    (mplier_chain[k]),
      .mcand_in     (mcand_chain[k]),
      .done         (start_chain[k+1]),
      .product_out  (),
      .mplier_out   (mplier_chain[k+1]),
      .mcand_out    (mcand_chain[k+1]),
      .next_product (prod_chain[k+1])
    );
  end

  // tag rides along with its stage, same freeze
  always_ff @(posedge clock) begin
    if (!hazard) begin
      tag_q[0] <= op.tag;
      for (int k = 1; k < STAGES; k++) begin
        tag_q[k] <= tag_q[k-1];
      end
    end
  end

  // last stage adds its own slice combinationally
  assign result.value   = prod_chain[STAGES];
  assign result.tag     = tag_q[STAGES-1];
  assign result.illegal = 1'b0;
  assign done           = start_chain[STAGES];

  // all stages freeze together, so no entry under hazard
  // covers the last stage holding a finished product too
  assign ready = !(hazard && (op.valid || done));

endmodule

//--- design/mult_stage.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module mult_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     hazard,
  input  logic [`FU_WORD_BITS-1:0] product_in,
  input  logic [`FU_WORD_BITS-1:0] mplier_in,
  input  logic [`FU_WORD_BITS-1:0] mcand_in,
  output logic                     done,
  output logic [`FU_WORD_BITS-1:0] product_out,
  output logic [`FU_WORD_BITS-1:0] mplier_out,
  output logic [`FU_WORD_BITS-1:0] mcand_out,
  output logic [`FU_WORD_BITS-1:0] next_product
);

  // multiplier bits retired per stage
  localparam int SLICE_BITS = `FU_WORD_BITS / `FU_MULT_STAGES;

  logic [`FU_WORD_BITS-1:0] mplier_q;
  logic [`FU_WORD_BITS-1:0] mcand_q;
  logic [`FU_WORD_BITS-1:0] partial;

  // capture running product and operands, hold on hazard
  always_ff @(posedge clock) begin
    if (!hazard) begin
      product_out <= product_in;
      mplier_q    <= mplier_in;
      mcand_q     <= mcand_in;
    end
  end

  // done freezes with the data so nothing drops under stall
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (!hazard) begin
      done <= start;
    end
  end

  // low slice of multiplier times whole multiplicand, low word kept
  assign partial      = mplier_q[SLICE_BITS-1:0] * mcand_q;
  assign next_product = product_out + partial;

  // line up the next slice for the following stage
  assign mplier_out = mplier_q >> SLICE_BITS;
  assign mcand_out  = mcand_q << SLICE_BITS;

endmodule

//--- design/alu.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module alu (
  input  fu_pkg::exec_packet_t op,
  input  logic                illegal,
  input  logic                hazard,
  output fu_pkg::fu_result_t  result,
  output logic                done,
  output logic                ready
);

  localparam int W = `FU_WORD_BITS;

  logic [W-1:0] a;
  logic [W-1:0] b;
  logic [5:0]   shamt;
  logic         ult;
  logic         eq;
  logic         slt;
  logic [W-1:0] sign_fill;

  assign a     = op.a;
  assign b     = op.b;
  // only the low six bits count as shift amount
  assign shamt = b[5:0];

  assign ult = a < b;
  assign eq  = a == b;
  // same sign means unsigned order holds, else the negative one is less
  assign slt = (a[W-1] == b[W-1]) ? ult : a[W-1];

  // ones in the top shamt bits, only for negative a
  assign sign_fill = ~({W{1'b1}} >> shamt) & {W{a[W-1]}};

  always_comb begin
    case (op.func)
      fu_pkg::alu_addq:   result.value = a + b;
      fu_pkg::alu_subq:   result.value = a - b;
      fu_pkg::alu_and:    result.value = a & b;
      fu_pkg::alu_bic:    result.value = a & ~b;
      fu_pkg::alu_bis:    result.value = a | b;
      fu_pkg::alu_ornot:  result.value = a | ~b;
      fu_pkg::alu_xor:    result.value = a ^ b;
      fu_pkg::alu_eqv:    result.value = a ^ ~b;
      fu_pkg::alu_srl:    result.value = a >> shamt;
      fu_pkg::alu_sll:    result.value = a << shamt;
      // arithmetic shift from logical shift plus sign fill
      fu_pkg::alu_sra:    result.value = (a >> shamt) | sign_fill;
      fu_pkg::alu_cmpult: result.value = {{(W-1){1'b0}}, ult};
      fu_pkg::alu_cmpeq:  result.value = {{(W-1){1'b0}}, eq};
      fu_pkg::alu_cmpule: result.value = {{(W-1){1'b0}}, ult || eq};
      fu_pkg::alu_cmplt:  result.value = {{(W-1){1'b0}}, slt};
      fu_pkg::alu_cmple:  result.value = {{(W-1){1'b0}}, slt || eq};
      default:            result.value = '0;
    endcase
  end

  assign result.tag     = op.tag;
  assign result.illegal = illegal;

  // single cycle, finished as soon as it arrives
  assign done  = op.valid;
  // held at issue while the arbiter says no
  assign ready = !(op.valid && hazard);

endmodule

//--- design/operand_decode.sv
`timescale 1ns/100ps

module operand_decode (
  input  logic                 issue_valid,
  input  fu_pkg::issue_packet_t issue,
  output fu_pkg::exec_packet_t  alu_op,
  output fu_pkg::exec_packet_t  mult_op,
  output logic                 illegal
);

  // integer operate opcode groups
  localparam logic [5:0] OP_INTA = 6'h10;
  localparam logic [5:0] OP_INTL = 6'h11;
  localparam logic [5:0] OP_INTS = 6'h12;
  localparam logic [5:0] OP_INTM = 6'h13;

  logic [5:0]       opcode;
  logic [6:0]       fn;
  logic             is_lit;
  logic [63:0]      opnd_b;
  fu_pkg::alu_func_e func;
  logic             is_mult;
  logic             known;

  // opcode and function code sit in the same place in both views
  assign opcode = issue.inst.reg_form.opcode;
  assign fn     = issue.inst.reg_form.func;
  assign is_lit = issue.inst.reg_form.lit_flag;

  // literal form replaces rb with a zero-extended 8-bit constant
  assign opnd_b = is_lit ? {56'd0, issue.inst.lit_form.lit} : issue.b_value;

  always_comb begin
    func    = fu_pkg::alu_addq;
    is_mult = 1'b0;
    known   = 1'b1;
    case (opcode)
      // arithmetic and compares
      OP_INTA: begin
        case (fn)
          7'h20:   func = fu_pkg::alu_addq;
          7'h29:   func = fu_pkg::alu_subq;
          7'h1d:   func = fu_pkg::alu_cmpult;
          7'h2d:   func = fu_pkg::alu_cmpeq;
          7'h3d:   func = fu_pkg::alu_cmpule;
          7'h4d:   func = fu_pkg::alu_cmplt;
          7'h6d:   func = fu_pkg::alu_cmple;
          default: known = 1'b0;
        endcase
      end
      // logical
      OP_INTL: begin
        case (fn)
          7'h00:   func = fu_pkg::alu_and;
          7'h08:   func = fu_pkg::alu_bic;
          7'h20:   func = fu_pkg::alu_bis;
          7'h28:   func = fu_pkg::alu_ornot;
          7'h40:   func = fu_pkg::alu_xor;
          7'h48:   func = fu_pkg::alu_eqv;
          default: known = 1'b0;
        endcase
      end
      // shifts
      OP_INTS: begin
        case (fn)
          7'h34:   func = fu_pkg::alu_srl;
          7'h39:   func = fu_pkg::alu_sll;
          7'h3c:   func = fu_pkg::alu_sra;
          default: known = 1'b0;
        endcase
      end
      // only mulq goes to the multiplier
      OP_INTM: begin
        if (fn == 7'h20) begin
          is_mult = 1'b1;
        end else begin
          known = 1'b0;
        end
      end
      default: known = 1'b0;
    endcase
  end

  assign illegal = issue_valid && !known;

  // unknown ops become addq of zeros so the value comes out zero
  assign alu_op.valid = issue_valid && !is_mult;
  assign alu_op.func  = func;
  assign alu_op.a     = known ? issue.a_value : '0;
  assign alu_op.b     = known ? opnd_b : '0;
  assign alu_op.tag   = issue.tag;

  // func unused by the multiplier
  assign mult_op.valid = issue_valid && is_mult;
  assign mult_op.func  = fu_pkg::alu_addq;
  assign mult_op.a     = issue.a_value;
  assign mult_op.b     = opnd_b;
  assign mult_op.tag   = issue.tag;

endmodule

//--- design/fu_pkg.sv
`include "fu_defines.svh"

package fu_pkg;

  // operate format with register operand b
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [4:0] rb;
    // must be zero in this form
    logic [2:0] sbz;
    logic       lit_flag;
    logic [6:0] func;
    logic [4:0] rc;
  } inst_reg_form_t;

  // operate format with 8-bit literal in place of rb
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [7:0] lit;
    logic       lit_flag;
    logic [6:0] func;
    logic [4:0] rc;
  } inst_lit_form_t;

  // one instruction word, view chosen by lit_flag
  typedef union packed {
    inst_reg_form_t reg_form;
    inst_lit_form_t lit_form;
  } alpha_inst_t;

  // alu function select
  typedef enum logic [3:0] {
    alu_addq,
    alu_subq,
    alu_and,
    alu_bic,
    alu_bis,
    alu_ornot,
    alu_xor,
    alu_eqv,
    alu_srl,
    alu_sll,
    alu_sra,
    alu_cmpult,
    alu_cmpeq,
    alu_cmpule,
    alu_cmplt,
    alu_cmple
  } alu_func_e;

  // what the issue stage hands over
  typedef struct packed {
    alpha_inst_t              inst;
    logic [`FU_WORD_BITS-1:0] a_value;
    logic [`FU_WORD_BITS-1:0] b_value;
    logic [`FU_TAG_BITS-1:0]  tag;
  } issue_packet_t;

  // decoded op for one execute unit, operands already selected
  typedef struct packed {
    logic                     valid;
    alu_func_e                func;
    logic [`FU_WORD_BITS-1:0] a;
    logic [`FU_WORD_BITS-1:0] b;
    logic [`FU_TAG_BITS-1:0]  tag;
  } exec_packet_t;

  // one finished result
  typedef struct packed {
    logic [`FU_WORD_BITS-1:0] value;
    logic [`FU_TAG_BITS-1:0]  tag;
    logic                     illegal;
  } fu_result_t;

endpackage

//--- design/fu_defines.svh
`ifndef FU_DEFINES_SVH
`define FU_DEFINES_SVH

// data word width, one integer register
`define FU_WORD_BITS 64

// physical destination tag width
`define FU_TAG_BITS 6

// multiplier pipeline depth
// each stage retires FU_WORD_BITS / FU_MULT_STAGES multiplier bits
// 2, 4 and 8 all divide the word evenly
`define FU_MULT_STAGES 4

`endif
